// File: verilog/output_gate_pkg.sv
// Fixed sizes only (N = 4, Q8.8 in 16 bits); the address map is tied to these values
`default_nettype none

package output_gate_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes and number format
  ////////////////////////////////////////////////////////////////////////////

  // Vector length and matrix order
  localparam int VEC_LEN = 4;
  // Q8.8 data word
  localparam int DATA_W = 16;
  localparam int FRAC_W = 8;
  // Room for 12 Q16.16 products plus the bias
  localparam int ACC_W = 40;
  // Wishbone word address
  localparam int ADR_W = 8;
  // 1.0 in Q8.8
  localparam int ONE_Q = 256;
  // Products per row: W*x, K*r, U*h
  localparam int NUM_TERMS = 3;

  // Operand area spans 0x10 to 0x4F
  localparam int OPR_WORDS = 64;
  localparam int OPR_AW = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [ADR_W-1:0] ADR_CTRL   = 8'h00;
  localparam logic [ADR_W-1:0] ADR_STATUS = 8'h01;
  // Matrices row-major
  localparam logic [ADR_W-1:0] BASE_W = 8'h10;
  localparam logic [ADR_W-1:0] BASE_K = 8'h20;
  localparam logic [ADR_W-1:0] BASE_U = 8'h30;
  // Vectors
  localparam logic [ADR_W-1:0] BASE_X = 8'h40;
  localparam logic [ADR_W-1:0] BASE_R = 8'h44;
  localparam logic [ADR_W-1:0] BASE_H = 8'h48;
  localparam logic [ADR_W-1:0] BASE_B = 8'h4C;
  // Result vector, host read-only
  localparam logic [ADR_W-1:0] BASE_O = 8'h50;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Operand picked by the sequencer read port
  typedef enum logic [2:0] {OP_W, OP_K, OP_U, OP_X, OP_R, OP_H, OP_B} operand_t;

  // Accumulator opcodes
  typedef enum logic [1:0] {MAC_LOAD, MAC_ACC, MAC_HOLD} mac_op_t;

  // Sequencer states
  typedef enum logic [2:0] {ST_IDLE, ST_MAC, ST_BIAS, ST_ACT, ST_STORE} gate_state_t;

endpackage

`default_nettype wire

// File: verilog/gate_regs.sv
// Wishbone classic slave; host must hold cyc and stb until ack, operand writes ignored while busy
`timescale 1ns/100ps
`default_nettype none

module gate_regs import output_gate_pkg::*; (
  input  wire logic              CLK,
  input  wire logic              RST,
  input  wire logic              wb_cyc,
  input  wire logic              wb_stb,
  input  wire logic              wb_we,
  input  wire logic [ADR_W-1:0]  wb_adr,
  input  wire logic [DATA_W-1:0] wb_dat_w,
  output      logic [DATA_W-1:0] wb_dat_r,
  output      logic              wb_ack,
  output      logic              start,
  output      logic              irq,
  input  wire logic              busy,
  input  wire logic              done,
  input  wire operand_t          op_sel,
  input  wire logic [1:0]        op_row,
  input  wire logic [1:0]        op_col,
  output      logic [DATA_W-1:0] op_data,
  input  wire logic              res_we,
  input  wire logic [1:0]        res_idx,
  input  wire logic [DATA_W-1:0] res_data
);

  // Operand store W, K, U, x, r, h, b in address order
  logic [DATA_W-1:0] opr_mem [OPR_WORDS];
  // Result vector o
  logic [DATA_W-1:0] res_mem [VEC_LEN];

  logic              host_wr;
  logic              in_opr;
  logic              in_res;
  logic [OPR_AW-1:0] wb_idx;
  logic [1:0]        res_sel;
  logic [ADR_W-1:0]  op_adr;
  logic [OPR_AW-1:0] op_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Bus handshake and decode
  ////////////////////////////////////////////////////////////////////////////

  // Single-cycle ack one cycle after the request is seen
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_cyc & wb_stb & ~wb_ack;
    end
  end

  // Writes land on the ack cycle
  assign host_wr = wb_ack & wb_we;

  assign in_opr  = (wb_adr >= BASE_W) && (wb_adr < BASE_O);
  assign in_res  = (wb_adr >= BASE_O) && (wb_adr < BASE_O + ADR_W'(VEC_LEN));
  assign wb_idx  = OPR_AW'(wb_adr - BASE_W);
  assign res_sel = 2'(wb_adr - BASE_O);

  // Start only from idle
  assign start = host_wr & (wb_adr == ADR_CTRL) & wb_dat_w[0] & ~busy;

  // Interrupt mirrors the done flag
  assign irq = done;

  // Read mux; valid while ack is high since the host holds the address
  always_comb begin
    wb_dat_r = '0;
    if (wb_adr == ADR_STATUS) begin
      wb_dat_r = {{(DATA_W-2){1'b0}}, done, busy};
    end else if (in_opr) begin
      wb_dat_r = opr_mem[wb_idx];
    end else if (in_res) begin
      wb_dat_r = res_mem[res_sel];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand and result storage
  ////////////////////////////////////////////////////////////////////////////

  // Host side of the operand store, locked during a run
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < OPR_WORDS; i++) begin
        opr_mem[i] <= '0;
      end
    end else if (host_wr && in_opr && !busy) begin
      opr_mem[wb_idx] <= wb_dat_w;
    end
  end

  // Result words come only from the datapath
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < VEC_LEN; i++) begin
        res_mem[i] <= '0;
      end
    end else if (res_we) begin
      res_mem[res_idx] <= res_data;
    end
  end

  // Sequencer read port
  // Matrices take row and column, vectors take the row only
  always_comb begin
    case (op_sel)
      OP_W:    op_adr = BASE_W + ADR_W'({op_row, op_col});
      OP_K:    op_adr = BASE_K + ADR_W'({op_row, op_col});
      OP_U:    op_adr = BASE_U + ADR_W'({op_row, op_col});
      OP_X:    op_adr = BASE_X + ADR_W'(op_row);
      OP_R:    op_adr = BASE_R + ADR_W'(op_row);
      OP_H:    op_adr = BASE_H + ADR_W'(op_row);
      default: op_adr = BASE_B + ADR_W'(op_row);
    endcase
  end

  assign op_idx  = OPR_AW'(op_adr - BASE_W);
  assign op_data = opr_mem[op_idx];

endmodule

`default_nettype wire

// File: verilog/gate_sequencer.sv
// One run is 4 rows of 27 cycles; operands must stay stable while busy
`timescale 1ns/100ps
`default_nettype none

module gate_sequencer import output_gate_pkg::*; (
  input  wire logic              CLK,
  input  wire logic              RST,
  input  wire logic              start,
  output      logic              busy,
  output      logic              done,
  output      operand_t          op_sel,
  output      logic [1:0]        op_row,
  output      logic [1:0]        op_col,
  input  wire logic [DATA_W-1:0] op_data,
  output      mac_op_t           mac_op,
  output      logic [DATA_W-1:0] mac_a,
  output      logic [DATA_W-1:0] mac_b,
  output      logic              act_en,
  output      logic              res_we,
  output      logic [1:0]        res_idx
);

  gate_state_t       state;
  logic [1:0]        row;
  logic [1:0]        col;
  // 0 W*x, 1 K*r, 2 U*h
  logic [1:0]        term;
  // Low phase reads the matrix, high phase the vector
  logic              phase;
  // Matrix element held for the vector phase
  logic [DATA_W-1:0] mat_q;

  ////////////////////////////////////////////////////////////////////////////
  // State and counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ST_IDLE;
      row   <= '0;
      col   <= '0;
      term  <= '0;
      phase <= 1'b0;
      done  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_MAC;
            row   <= '0;
            col   <= '0;
            term  <= '0;
            phase <= 1'b0;
            done  <= 1'b0;
          end
        end
        ST_MAC: begin
          phase <= ~phase;
          // Step the column after the vector read
          if (phase) begin
            if (col == 2'(VEC_LEN-1)) begin
              col <= '0;
              if (term == 2'(NUM_TERMS-1)) begin
                term  <= '0;
                state <= ST_BIAS;
              end else begin
                term <= term + 2'd1;
              end
            end else begin
              col <= col + 2'd1;
            end
          end
        end
        ST_BIAS: begin
          state <= ST_ACT;
        end
        ST_ACT: begin
          state <= ST_STORE;
        end
        ST_STORE: begin
          if (row == 2'(VEC_LEN-1)) begin
            row   <= '0;
            state <= ST_IDLE;
            done  <= 1'b1;
          end else begin
            row   <= row + 2'd1;
            state <= ST_MAC;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Latch the matrix word on the low phase
  always_ff @(posedge CLK) begin
    if (state == ST_MAC && !phase) begin
      mat_q <= op_data;
    end
  end

  assign busy    = (state != ST_IDLE);
  assign res_idx = row;

  ////////////////////////////////////////////////////////////////////////////
  // Operand select and datapath steering
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    op_sel = OP_W;
    op_row = row;
    op_col = col;
    mac_op = MAC_HOLD;
    mac_a  = mat_q;
    mac_b  = op_data;
    act_en = 1'b0;
    res_we = 1'b0;
    case (state)
      ST_MAC: begin
        if (!phase) begin
          case (term)
            2'd0:    op_sel = OP_W;
            2'd1:    op_sel = OP_K;
            default: op_sel = OP_U;
          endcase
        end else begin
          case (term)
            2'd0:    op_sel = OP_X;
            2'd1:    op_sel = OP_R;
            default: op_sel = OP_H;
          endcase
          // Vector element follows the column
          op_row = col;
          // First product of the row restarts the sum
          mac_op = (term == 2'd0 && col == 2'd0) ? MAC_LOAD : MAC_ACC;
        end
      end
      ST_BIAS: begin
        // b(l) scaled to Q16.16
        op_sel = OP_B;
        mac_a  = op_data;
        mac_b  = DATA_W'(ONE_Q);
        mac_op = MAC_ACC;
      end
      ST_ACT: begin
        act_en = 1'b1;
      end
      ST_STORE: begin
        res_we = 1'b1;
      end
      default: begin
        mac_op = MAC_HOLD;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/matvec_mac.sv
// Signed Q8.8 by Q8.8 products summed in Q16.16; no overflow check on the 40-bit sum
`timescale 1ns/100ps
`default_nettype none

module matvec_mac import output_gate_pkg::*; (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire mac_op_t                 mac_op,
  input  wire logic [DATA_W-1:0]       mac_a,
  input  wire logic [DATA_W-1:0]       mac_b,
  output      logic signed [ACC_W-1:0] acc
);

  // Full-width product
  logic signed [2*DATA_W-1:0] prod;
  // Product widened to the accumulator
  logic signed [ACC_W-1:0]    prod_ext;

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////////////////////

  // Operands sign-extended to the product width
  assign prod = (2*DATA_W)'($signed(mac_a)) * (2*DATA_W)'($signed(mac_b));

  // Sign extension of the Q16.16 product
  assign prod_ext = {{(ACC_W-2*DATA_W){prod[2*DATA_W-1]}}, prod};

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else begin
      case (mac_op)
        // Start of a new row
        MAC_LOAD: acc <= prod_ext;
        MAC_ACC:  acc <= acc + prod_ext;
        // Hold through activation and store
        default:  acc <= acc;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/logistic_pwl.sv
// Hard sigmoid 0.5 + z/4 clamped to [0, 1]; not an exact logistic
`timescale 1ns/100ps
`default_nettype none

module logistic_pwl import output_gate_pkg::*; (
  input  wire logic                    CLK,
  input  wire logic                    RST,
  input  wire logic                    act_en,
  input  wire logic signed [ACC_W-1:0] acc,
  output      logic [DATA_W-1:0]       res_data
);

  logic signed [ACC_W-1:0]  z_wide;
  logic                     z_fits;
  logic signed [DATA_W-1:0] z;
  logic signed [DATA_W-1:0] quarter;
  logic signed [DATA_W:0]   o_wide;
  logic [DATA_W-1:0]        o_next;

  ////////////////////////////////////////////////////////////////////////////
  // Rescale and saturate
  ////////////////////////////////////////////////////////////////////////////

  // Q16.16 down to Q8.8
  assign z_wide = acc >>> FRAC_W;

  // Fits when every bit above the 16-bit sign matches it
  assign z_fits = (&z_wide[ACC_W-1:DATA_W-1]) | ~(|z_wide[ACC_W-1:DATA_W-1]);

  // Clip to the most positive or most negative word
  assign z = z_fits ? z_wide[DATA_W-1:0]
                    : {z_wide[ACC_W-1], {(DATA_W-1){~z_wide[ACC_W-1]}}};

  ////////////////////////////////////////////////////////////////////////////
  // Hard sigmoid
  ////////////////////////////////////////////////////////////////////////////

  // Slope of one quarter
  assign quarter = z >>> 2;

  // Offset of one half
  assign o_wide = (DATA_W+1)'(quarter) + (DATA_W+1)'(ONE_Q / 2);

  // Clamp to 0 .. 1.0
  always_comb begin
    if (o_wide[DATA_W]) begin
      o_next = '0;
    end else if (o_wide > (DATA_W+1)'(ONE_Q)) begin
      o_next = DATA_W'(ONE_Q);
    end else begin
      o_next = o_wide[DATA_W-1:0];
    end
  end

  // Result held for the store cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res_data <= '0;
    end else if (act_en) begin
      res_data <= o_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/output_gate_top.sv
// Wishbone classic slave only; irq is level, high from end of run until the next start
`timescale 1ns/100ps
`default_nettype none

module output_gate_top import output_gate_pkg::*; (
  input  wire logic              CLK,
  input  wire logic              RST,
  input  wire logic              wb_cyc,
  input  wire logic              wb_stb,
  input  wire logic              wb_we,
  input  wire logic [ADR_W-1:0]  wb_adr,
  input  wire logic [DATA_W-1:0] wb_dat_w,
  output      logic [DATA_W-1:0] wb_dat_r,
  output      logic              wb_ack,
  output      logic              irq
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  // Control between registers and sequencer
  logic                    start;
  logic                    busy;
  logic                    done;

  // Operand read port
  operand_t                op_sel;
  logic [1:0]              op_row;
  logic [1:0]              op_col;
  logic [DATA_W-1:0]       op_data;

  // Datapath
  mac_op_t                 mac_op;
  logic [DATA_W-1:0]       mac_a;
  logic [DATA_W-1:0]       mac_b;
  logic signed [ACC_W-1:0] acc;
  logic                    act_en;

  // Result write
  logic                    res_we;
  logic [1:0]              res_idx;
  logic [DATA_W-1:0]       res_data;

  ////////////////////////////////////////////////////////////////////////////
  // Register block
  ////////////////////////////////////////////////////////////////////////////

  gate_regs u_regs (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .start    (start),
    .irq      (irq),
    .busy     (busy),
    .done     (done),
    .op_sel   (op_sel),
    .op_row   (op_row),
    .op_col   (op_col),
    .op_data  (op_data),
    .res_we   (res_we),
    .res_idx  (res_idx),
    .res_data (res_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  gate_sequencer u_seq (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .op_sel  (op_sel),
    .op_row  (op_row),
    .op_col  (op_col),
    .op_data (op_data),
    .mac_op  (mac_op),
    .mac_a   (mac_a),
    .mac_b   (mac_b),
    .act_en  (act_en),
    .res_we  (res_we),
    .res_idx (res_idx)
  );

  // Sum of the three products and the bias
  matvec_mac u_mac (
    .CLK    (CLK),
    .RST    (RST),
    .mac_op (mac_op),
    .mac_a  (mac_a),
    .mac_b  (mac_b),
    .acc    (acc)
  );

  // Activation feeding the result store
  logistic_pwl u_act (
    .CLK      (CLK),
    .RST      (RST),
    .act_en   (act_en),
    .acc      (acc),
    .res_data (res_data)
  );

endmodule

`default_nettype wire

// File: tests/output_gate_checker.sv
// Bus and sequencer properties checked at every rising CLK outside reset; bound into gate_regs
`timescale 1ns/100ps
`default_nettype none

module output_gate_checker (
  input wire logic CLK,
  input wire logic RST,
  input wire logic wb_cyc,
  input wire logic wb_stb,
  input wire logic wb_ack,
  input wire logic busy,
  input wire logic done,
  input wire logic res_we
);

  // Failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone slave
  ////////////////////////////////////////////////////////////////////////////

  // Ack lasts one cycle
  ack_single: assert property (@(posedge CLK) disable iff (RST) wb_ack |=> !wb_ack)
    else begin
      fail_count++;
      $error("wb_ack high on two cycles in a row");
    end

  // No ack without a request
  ack_req: assert property (@(posedge CLK) disable iff (RST) wb_ack |-> (wb_cyc && wb_stb))
    else begin
      fail_count++;
      $error("wb_ack without wb_cyc and wb_stb");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  status_excl: assert property (@(posedge CLK) disable iff (RST) !(busy && done))
    else begin
      fail_count++;
      $error("busy and done high together");
    end

  // Results written only inside a run
  store_busy: assert property (@(posedge CLK) disable iff (RST) res_we |-> busy)
    else begin
      fail_count++;
      $error("res_we outside a run");
    end

endmodule

bind gate_regs output_gate_checker u_chk (
  .CLK    (CLK),
  .RST    (RST),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .busy   (busy),
  .done   (done),
  .res_we (res_we)
);

`default_nettype wire

// File: tests/output_gate_tb.sv
// Reads tests/output_gate_tests.txt relative to the run directory; holds at most MAX_SETS sets
`timescale 1ns/100ps
`default_nettype none

module output_gate_tb import output_gate_pkg::*; ();

  localparam int MAX_SETS   = 4;
  // 64 operand words and 4 expected words per set
  localparam int SET_WORDS  = 68;
  localparam int EXP_OFS    = 64;
  localparam int CLK_HALF   = 50;
  localparam int RST_CYCLES = 5;
  localparam int ACK_LIMIT  = 8;
  localparam int POLL_LIMIT = 200;
  // Budget per set: 76 accesses of 3 cycles plus the run
  localparam int SET_CYCLES = 76 * 3 + 200;

  logic              CLK = 1'b0;
  logic              RST;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADR_W-1:0]  wb_adr;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;
  logic              irq;

  logic [DATA_W-1:0] tdata [1 + MAX_SETS * SET_WORDS];
  logic [DATA_W-1:0] shadow [OPR_WORDS];
  int                num_sets;
  bit                loaded = 1'b0;
  int                mismatches = 0;
  int                failures = 0;

  output_gate_top UUT (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .irq      (irq)
  );

  always begin
    #CLK_HALF CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus access and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Request on a falling edge, hold through the ack cycle, release after it
  task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                            input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
    int waited;
    waited = 0;
    rdat = '0;
    @(negedge CLK);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    @(negedge CLK);
    while (!wb_ack && waited < ACK_LIMIT) begin
      waited++;
      @(negedge CLK);
    end
    if (wb_ack) begin
      rdat = wb_dat_r;
    end else begin
      failures++;
      $display("Time %0t: no ack for the access to address %h", $time, adr);
    end
    @(negedge CLK);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] wdat);
    logic [DATA_W-1:0] unused_rd;
    bus_access(1'b1, adr, wdat, unused_rd);
  endtask

  task automatic bus_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] rdat);
    bus_access(1'b0, adr, '0, rdat);
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Bit 0 busy, bit 1 done, the rest zero
  task automatic check_status(input logic [DATA_W-1:0] got, input logic exp_busy,
                              input logic exp_done);
    logic [DATA_W-1:0] exp;
    exp = {{(DATA_W-2){1'b0}}, exp_done, exp_busy};
    if (got !== exp) begin
      mismatches++;
      $display("Error at %0t: STATUS is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic wait_done();
    logic [DATA_W-1:0] st;
    int                polls;
    polls = 0;
    st = '0;
    while (!st[1] && polls < POLL_LIMIT) begin
      bus_read(ADR_STATUS, st);
      polls++;
    end
    if (!st[1]) begin
      failures++;
      $display("Time %0t: done never set after %0d status polls", $time, polls);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////////////////////////////////////////

  // Load a set, run it, compare o; with lock, disturb the operands mid-run
  task automatic run_set(input int s, input bit lock);
    logic [DATA_W-1:0] rd;
    int                base;
    base = 1 + s * SET_WORDS;
    for (int i = 0; i < OPR_WORDS; i++) begin
      bus_write(BASE_W + ADR_W'(i), tdata[base + i]);
    end
    bus_write(ADR_CTRL, 16'h0001);
    bus_read(ADR_STATUS, rd);
    check_status(rd, 1'b1, 1'b0);
    check_flag("irq", irq, 1'b0);
    if (lock) begin
      // W(1,0) and x(0) would both change row 1
      bus_write(BASE_W + 8'd4, 16'h7FFF);
      bus_write(BASE_X, 16'h1234);
      bus_write(ADR_CTRL, 16'h0001);
    end
    wait_done();
    bus_read(ADR_STATUS, rd);
    check_status(rd, 1'b0, 1'b1);
    check_flag("irq", irq, 1'b1);
    for (int i = 0; i < VEC_LEN; i++) begin
      bus_read(BASE_O + ADR_W'(i), rd);
      check_word($sformatf("o[%0d] of set %0d", i, s), rd, tdata[base + EXP_OFS + i]);
    end
    if (lock) begin
      bus_read(BASE_W + 8'd4, rd);
      check_word("W(1,0) after locked write", rd, tdata[base + 4]);
      bus_read(BASE_X, rd);
      check_word("x(0) after locked write", rd, tdata[base + 48]);
    end
  endtask

  // Watchdog, three extra set budgets for reset, readback and lock phases
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(num_sets + 3) * SET_CYCLES * 2 * CLK_HALF
             + RST_CYCLES * 2 * CLK_HALF;
    #(limit_ns);
    $display("Time %0t: watchdog expired before the tests finished", $time);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [DATA_W-1:0] rd;
    int unsigned       asrt_fails;
    void'($urandom(32'h6d6a));
    RST      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    $readmemh("tests/output_gate_tests.txt", tdata);
    num_sets = int'(tdata[0]);
    if (num_sets > MAX_SETS) begin
      failures++;
      $display("Data file holds %0d sets, only %0d fit", num_sets, MAX_SETS);
      num_sets = MAX_SETS;
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(negedge CLK);
    RST = 1'b0;

    // Reset state
    bus_read(ADR_STATUS, rd);
    check_status(rd, 1'b0, 1'b0);
    check_flag("irq", irq, 1'b0);
    for (int i = 0; i < VEC_LEN; i++) begin
      bus_read(BASE_O + ADR_W'(i), rd);
      check_word($sformatf("o[%0d] after reset", i), rd, '0);
    end

    // Random operand readback, read-only results, unmapped space
    for (int i = 0; i < OPR_WORDS; i++) begin
      shadow[i] = DATA_W'($urandom);
      bus_write(BASE_W + ADR_W'(i), shadow[i]);
    end
    for (int i = 0; i < OPR_WORDS; i++) begin
      bus_read(BASE_W + ADR_W'(i), rd);
      check_word($sformatf("operand word %h", BASE_W + ADR_W'(i)), rd, shadow[i]);
    end
    for (int i = 0; i < VEC_LEN; i++) begin
      bus_write(BASE_O + ADR_W'(i), DATA_W'($urandom));
      bus_read(BASE_O + ADR_W'(i), rd);
      check_word($sformatf("o[%0d] after host write", i), rd, '0);
    end
    bus_write(8'h60, 16'hA5A5);
    bus_read(8'h60, rd);
    check_word("unmapped word 60", rd, '0);

    // File-driven gate runs, then the busy lock on set 2
    for (int s = 0; s < num_sets; s++) begin
      run_set(s, 1'b0);
    end
    run_set(2, 1'b1);

    asrt_fails = UUT.u_regs.u_chk.fail_count;
    $display("Mismatches %0d, other failures %0d, assertion failures %0d",
             mismatches, failures, asrt_fails);
    if (mismatches == 0 && failures == 0 && asrt_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: output_gate.f
verilog/output_gate_pkg.sv
verilog/gate_regs.sv
verilog/gate_sequencer.sv
verilog/matvec_mac.sv
verilog/logistic_pwl.sv
verilog/output_gate_top.sv
tests/output_gate_checker.sv
tests/output_gate_tb.sv

// File: Makefile
# Verilator build and run for the output gate engine
# Override any variable on the command line, e.g. make test TOP=output_gate_tb

SIM      ?= verilator
TOP      ?= output_gate_tb
FLAGS    ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+100
OBJ_DIR  ?= obj_dir
FILELIST ?= output_gate.f
PASS_MSG ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run $(TOP); fails unless '$(PASS_MSG)' is printed"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: SIM TOP FLAGS RUN_ARGS OBJ_DIR FILELIST"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then echo "PASS"; \
	else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR)

// File: tests/output_gate_tests.txt
// Word 0 is the set count; per set W, K, U row-major (16 words each), then x r h b, then o
// One set per six lines: W / K / U / x r h b / expected o
0004
// Identity W, o follows x only
0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0100 0080 FF00 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
00C0 00A0 0040 0080
// Large sums saturate z, o clamps at 1.0 and 0
4000 4000 4000 4000 4000 4000 4000 4000 C000 C000 C000 C000 C000 C000 C000 C000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
4000 4000 4000 4000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0100 0100 0000 0000
// All three products and the bias
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0200 0000 0000 0000 0000 0200 0000 0000 0000 0000 0200 0000 0000 0000 0000 0200
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 FE00 0000 0000 0000 0000
0040 0040 0040 0040 0080 FF80 0000 0100 0000 0000 0000 0080 0000 0100 FF00 FD80
0100 00C0 0040 00A0
// Small negative values, arithmetic shifts round down
0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100
0080 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
FFFF 0003 FFFD 00FF 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
007F 0080 007F 00BF
